// File: design/scan_out_pkg.sv
// Shared widths, select encodings and output reset levels for the scan-out path.
// Every registered output resets low, including the active-low blank and sync.

package scan_out_pkg;

    // Bits per colour channel, default for all stages
    localparam int COLOR_W = 8;

    // OSD colour code, one bit per channel, red in the MSB
    localparam int OSD_COLOR_W = 3;

    // Capture source, the high bit picks the decoder
    typedef enum logic [1:0] {
        SRC_ISL     = 2'd0,
        SRC_HDMIRX  = 2'd1,
        SRC_SDP     = 2'd2,
        SRC_SDP_ALT = 2'd3
    } capture_src_e;

    // Extra analog output modes
    typedef enum logic [1:0] {
        MODE_RGBHV    = 2'd0,
        MODE_RGBCS    = 2'd1,
        MODE_RGSB     = 2'd2,
        MODE_RGSB_ALT = 2'd3
    } extra_out_mode_e;

    // Reset level of hsync, vsync and de on every stage
    localparam logic PIX_CTRL_RST = 1'b0;

    // Analog DAC control levels after reset
    localparam logic VGA_BLANK_N_RST = 1'b0;
    localparam logic VGA_SYNC_N_RST  = 1'b0;

endpackage

// File: design/pixel_if.sv
// One pixel per clock with its syncs; no handshake, every cycle carries a pixel.
// Width follows COLOR_W of the instantiating level.

`timescale 1ns/1ns

interface pixel_if import scan_out_pkg::*; #(
    parameter int COLOR_W = scan_out_pkg::COLOR_W
);

    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
    logic               hsync;
    logic               vsync;
    logic               de;

    // Producing stage
    modport src (
        output r, g, b, hsync, vsync, de
    );

    // Consuming stage
    modport snk (
        input r, g, b, hsync, vsync, de
    );

endinterface

// File: design/capture_select.sv
// Registers the selected source; one cycle from input pins to cap_o.
// All sources must already be on CLK27_i, no synchronisation happens here.

`timescale 1ns/1ns

module capture_select import scan_out_pkg::*; #(
    parameter int COLOR_W = scan_out_pkg::COLOR_W
) (
    input  logic               CLK27_i,
    input  logic               po_reset_n,
    input  capture_src_e       src_sel_i,
    input  logic [COLOR_W-1:0] isl_r_i,
    input  logic [COLOR_W-1:0] isl_g_i,
    input  logic [COLOR_W-1:0] isl_b_i,
    input  logic               isl_hs_i,
    input  logic               isl_vs_i,
    input  logic               isl_de_i,
    input  logic [COLOR_W-1:0] hdmirx_r_i,
    input  logic [COLOR_W-1:0] hdmirx_g_i,
    input  logic [COLOR_W-1:0] hdmirx_b_i,
    input  logic               hdmirx_hs_i,
    input  logic               hdmirx_vs_i,
    input  logic               hdmirx_de_i,
    input  logic [COLOR_W-1:0] sdp_r_i,
    input  logic [COLOR_W-1:0] sdp_g_i,
    input  logic [COLOR_W-1:0] sdp_b_i,
    input  logic               sdp_hs_i,
    input  logic               sdp_vs_i,
    input  logic               sdp_de_i,
    pixel_if.src               cap_o
);

    logic [3*COLOR_W+2:0] sel_pix;

    // Decoder wins whenever the high select bit is set
    always_comb begin
        case (src_sel_i)
            SRC_SDP, SRC_SDP_ALT: begin
                sel_pix = {sdp_r_i, sdp_g_i, sdp_b_i, sdp_hs_i, sdp_vs_i, sdp_de_i};
            end
            SRC_HDMIRX: begin
                sel_pix = {hdmirx_r_i, hdmirx_g_i, hdmirx_b_i,
                           hdmirx_hs_i, hdmirx_vs_i, hdmirx_de_i};
            end
            default: begin
                sel_pix = {isl_r_i, isl_g_i, isl_b_i, isl_hs_i, isl_vs_i, isl_de_i};
            end
        endcase
    end

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            cap_o.r     <= '0;
            cap_o.g     <= '0;
            cap_o.b     <= '0;
            cap_o.hsync <= PIX_CTRL_RST;
            cap_o.vsync <= PIX_CTRL_RST;
            cap_o.de    <= PIX_CTRL_RST;
        end else begin
            {cap_o.r, cap_o.g, cap_o.b, cap_o.hsync, cap_o.vsync, cap_o.de} <= sel_pix;
        end
    end

endmodule

// File: design/osd_overlay.sv
// OSD colour replaces the pixel while osd_enable_i is high; syncs pass unchanged.
// out_o is the merged pixel, the HDMI pins follow it by one more register.

`timescale 1ns/1ns

module osd_overlay import scan_out_pkg::*; #(
    parameter int COLOR_W = scan_out_pkg::COLOR_W
) (
    input  logic                   CLK27_i,
    input  logic                   po_reset_n,
    pixel_if.snk                   cap_i,
    input  logic                   osd_enable_i,
    input  logic [OSD_COLOR_W-1:0] osd_color_i,
    pixel_if.src                   out_o,
    output logic [COLOR_W-1:0]     hdmitx_r_o,
    output logic [COLOR_W-1:0]     hdmitx_g_o,
    output logic [COLOR_W-1:0]     hdmitx_b_o,
    output logic                   hdmitx_hsync_o,
    output logic                   hdmitx_vsync_o,
    output logic                   hdmitx_de_o
);

    // Merge stage
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            {out_o.r, out_o.g, out_o.b} <= '0;
            out_o.hsync <= PIX_CTRL_RST;
            out_o.vsync <= PIX_CTRL_RST;
            out_o.de    <= PIX_CTRL_RST;
        end else begin
            if (osd_enable_i) begin
                out_o.r <= {COLOR_W{osd_color_i[2]}};
                out_o.g <= {COLOR_W{osd_color_i[1]}};
                out_o.b <= {COLOR_W{osd_color_i[0]}};
            end else begin
                {out_o.r, out_o.g, out_o.b} <= {cap_i.r, cap_i.g, cap_i.b};
            end
            out_o.hsync <= cap_i.hsync;
            out_o.vsync <= cap_i.vsync;
            out_o.de    <= cap_i.de;
        end
    end

    // Launch register for the transmitter pins
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            {hdmitx_r_o, hdmitx_g_o, hdmitx_b_o} <= '0;
            hdmitx_hsync_o <= PIX_CTRL_RST;
            hdmitx_vsync_o <= PIX_CTRL_RST;
            hdmitx_de_o    <= PIX_CTRL_RST;
        end else begin
            {hdmitx_r_o, hdmitx_g_o, hdmitx_b_o} <= {out_o.r, out_o.g, out_o.b};
            hdmitx_hsync_o <= out_o.hsync;
            hdmitx_vsync_o <= out_o.vsync;
            hdmitx_de_o    <= out_o.de;
        end
    end

endmodule

// File: design/analog_sync_format.sv
// Two enabled stages to the analog DAC; both hold while extra_out_en_i is low.
// Mode code 3 behaves as sync-on-green. Composite sync assumes active-low syncs.

`timescale 1ns/1ns

module analog_sync_format import scan_out_pkg::*; #(
    parameter int COLOR_W = scan_out_pkg::COLOR_W
) (
    input  logic               CLK27_i,
    input  logic               po_reset_n,
    pixel_if.snk               pix_i,
    input  logic               extra_out_en_i,
    input  extra_out_mode_e    mode_i,
    output logic [COLOR_W-1:0] vga_r_o,
    output logic [COLOR_W-1:0] vga_g_o,
    output logic [COLOR_W-1:0] vga_b_o,
    output logic               vga_hs_o,
    output logic               vga_vs_o,
    output logic               vga_blank_n_o,
    output logic               vga_sync_n_o
);

    logic [COLOR_W-1:0] r_pre, g_pre, b_pre;
    logic               hs_pre, vs_pre, blank_n_pre, sync_n_pre;
    logic               csync;
    logic               hs_nxt, vs_nxt, sync_n_nxt;

    assign csync = ~(pix_i.hsync ^ pix_i.vsync);

    always_comb begin
        case (mode_i)
            MODE_RGBHV: begin
                hs_nxt     = pix_i.hsync;
                vs_nxt     = pix_i.vsync;
                sync_n_nxt = 1'b0;
            end
            MODE_RGBCS: begin
                hs_nxt     = csync;
                vs_nxt     = 1'b1;
                sync_n_nxt = 1'b0;
            end
            // Sync also goes on green through the DAC sync input
            MODE_RGSB, MODE_RGSB_ALT: begin
                hs_nxt     = csync;
                vs_nxt     = 1'b1;
                sync_n_nxt = csync;
            end
            default: begin
                hs_nxt     = pix_i.hsync;
                vs_nxt     = pix_i.vsync;
                sync_n_nxt = 1'b0;
            end
        endcase
    end

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            {r_pre, g_pre, b_pre} <= '0;
            hs_pre      <= PIX_CTRL_RST;
            vs_pre      <= PIX_CTRL_RST;
            blank_n_pre <= VGA_BLANK_N_RST;
            sync_n_pre  <= VGA_SYNC_N_RST;
            {vga_r_o, vga_g_o, vga_b_o} <= '0;
            vga_hs_o      <= PIX_CTRL_RST;
            vga_vs_o      <= PIX_CTRL_RST;
            vga_blank_n_o <= VGA_BLANK_N_RST;
            vga_sync_n_o  <= VGA_SYNC_N_RST;
        end else if (extra_out_en_i) begin
            {r_pre, g_pre, b_pre} <= {pix_i.r, pix_i.g, pix_i.b};
            hs_pre      <= hs_nxt;
            vs_pre      <= vs_nxt;
            blank_n_pre <= pix_i.de;
            sync_n_pre  <= sync_n_nxt;
            {vga_r_o, vga_g_o, vga_b_o} <= {r_pre, g_pre, b_pre};
            vga_hs_o      <= hs_pre;
            vga_vs_o      <= vs_pre;
            vga_blank_n_o <= blank_n_pre;
            vga_sync_n_o  <= sync_n_pre;
        end
    end

endmodule

// File: design/scan_out.sv
// Output path top: capture select, OSD merge, HDMI pins and extra analog output.
// Pins to HDMI take 3 cycles, pins to VGA 4 while extra_out_en_i stays high.

`timescale 1ns/1ns

module scan_out import scan_out_pkg::*; #(
    parameter int COLOR_W = scan_out_pkg::COLOR_W
) (
    input  logic                   CLK27_i,
    input  logic                   po_reset_n,
    input  capture_src_e           src_sel_i,
    input  logic [COLOR_W-1:0]     isl_r_i,
    input  logic [COLOR_W-1:0]     isl_g_i,
    input  logic [COLOR_W-1:0]     isl_b_i,
    input  logic                   isl_hs_i,
    input  logic                   isl_vs_i,
    input  logic                   isl_de_i,
    input  logic [COLOR_W-1:0]     hdmirx_r_i,
    input  logic [COLOR_W-1:0]     hdmirx_g_i,
    input  logic [COLOR_W-1:0]     hdmirx_b_i,
    input  logic                   hdmirx_hs_i,
    input  logic                   hdmirx_vs_i,
    input  logic                   hdmirx_de_i,
    input  logic [COLOR_W-1:0]     sdp_r_i,
    input  logic [COLOR_W-1:0]     sdp_g_i,
    input  logic [COLOR_W-1:0]     sdp_b_i,
    input  logic                   sdp_hs_i,
    input  logic                   sdp_vs_i,
    input  logic                   sdp_de_i,
    input  logic                   osd_enable_i,
    input  logic [OSD_COLOR_W-1:0] osd_color_i,
    input  logic                   extra_out_en_i,
    input  extra_out_mode_e        extra_out_mode_i,
    output logic [COLOR_W-1:0]     hdmitx_r_o,
    output logic [COLOR_W-1:0]     hdmitx_g_o,
    output logic [COLOR_W-1:0]     hdmitx_b_o,
    output logic                   hdmitx_hsync_o,
    output logic                   hdmitx_vsync_o,
    output logic                   hdmitx_de_o,
    output logic [COLOR_W-1:0]     vga_r_o,
    output logic [COLOR_W-1:0]     vga_g_o,
    output logic [COLOR_W-1:0]     vga_b_o,
    output logic                   vga_hs_o,
    output logic                   vga_vs_o,
    output logic                   vga_blank_n_o,
    output logic                   vga_sync_n_o
);

    pixel_if #(.COLOR_W(COLOR_W)) cap_bus ();
    pixel_if #(.COLOR_W(COLOR_W)) out_bus ();

    capture_select #(.COLOR_W(COLOR_W)) capture_select_i (
        .CLK27_i     (CLK27_i),
        .po_reset_n  (po_reset_n),
        .src_sel_i   (src_sel_i),
        .isl_r_i     (isl_r_i),
        .isl_g_i     (isl_g_i),
        .isl_b_i     (isl_b_i),
        .isl_hs_i    (isl_hs_i),
        .isl_vs_i    (isl_vs_i),
        .isl_de_i    (isl_de_i),
        .hdmirx_r_i  (hdmirx_r_i),
        .hdmirx_g_i  (hdmirx_g_i),
        .hdmirx_b_i  (hdmirx_b_i),
        .hdmirx_hs_i (hdmirx_hs_i),
        .hdmirx_vs_i (hdmirx_vs_i),
        .hdmirx_de_i (hdmirx_de_i),
        .sdp_r_i     (sdp_r_i),
        .sdp_g_i     (sdp_g_i),
        .sdp_b_i     (sdp_b_i),
        .sdp_hs_i    (sdp_hs_i),
        .sdp_vs_i    (sdp_vs_i),
        .sdp_de_i    (sdp_de_i),
        .cap_o       (cap_bus)
    );

    osd_overlay #(.COLOR_W(COLOR_W)) osd_overlay_i (
        .CLK27_i        (CLK27_i),
        .po_reset_n     (po_reset_n),
        .cap_i          (cap_bus),
        .osd_enable_i   (osd_enable_i),
        .osd_color_i    (osd_color_i),
        .out_o          (out_bus),
        .hdmitx_r_o     (hdmitx_r_o),
        .hdmitx_g_o     (hdmitx_g_o),
        .hdmitx_b_o     (hdmitx_b_o),
        .hdmitx_hsync_o (hdmitx_hsync_o),
        .hdmitx_vsync_o (hdmitx_vsync_o),
        .hdmitx_de_o    (hdmitx_de_o)
    );

    // Taps the merged pixel ahead of the HDMI launch register
    analog_sync_format #(.COLOR_W(COLOR_W)) analog_sync_format_i (
        .CLK27_i        (CLK27_i),
        .po_reset_n     (po_reset_n),
        .pix_i          (out_bus),
        .extra_out_en_i (extra_out_en_i),
        .mode_i         (extra_out_mode_i),
        .vga_r_o        (vga_r_o),
        .vga_g_o        (vga_g_o),
        .vga_b_o        (vga_b_o),
        .vga_hs_o       (vga_hs_o),
        .vga_vs_o       (vga_vs_o),
        .vga_blank_n_o  (vga_blank_n_o),
        .vga_sync_n_o   (vga_sync_n_o)
    );

endmodule

// File: sim/scan_out_assert.sv
// Checks on the analog sync pins and the HDMI state right after reset.
// Mode must be stable for two enabled cycles before its sync levels show up.

`timescale 1ns/1ns

module scan_out_assert import scan_out_pkg::*; #(
    parameter int COLOR_W = scan_out_pkg::COLOR_W
) (
    input logic               CLK27_i,
    input logic               po_reset_n,
    input logic               extra_out_en_i,
    input extra_out_mode_e    extra_out_mode_i,
    input logic               vga_vs_i,
    input logic               vga_sync_n_i,
    input logic [COLOR_W-1:0] hdmitx_r_i,
    input logic [COLOR_W-1:0] hdmitx_g_i,
    input logic [COLOR_W-1:0] hdmitx_b_i,
    input logic               hdmitx_hsync_i,
    input logic               hdmitx_vsync_i,
    input logic               hdmitx_de_i
);

    // Composite sync modes park vsync high
    vs_high_chk: assert property (@(posedge CLK27_i) disable iff (!po_reset_n)
        (extra_out_en_i && $past(extra_out_en_i) && extra_out_mode_i != MODE_RGBHV
         && $past(extra_out_mode_i) != MODE_RGBHV) |=> vga_vs_i)
        else $error("vga_vs_o went low in a composite sync mode");

    sync_n_low_chk: assert property (@(posedge CLK27_i) disable iff (!po_reset_n)
        (extra_out_en_i && $past(extra_out_en_i) && extra_out_mode_i == MODE_RGBHV
         && $past(extra_out_mode_i) == MODE_RGBHV) |=> !vga_sync_n_i)
        else $error("vga_sync_n_o went high in separate H/V sync mode");

    hdmi_reset_chk: assert property (@(posedge CLK27_i)
        $rose(po_reset_n) |-> (hdmitx_r_i == '0 && hdmitx_g_i == '0 && hdmitx_b_i == '0
                               && !hdmitx_hsync_i && !hdmitx_vsync_i && !hdmitx_de_i))
        else $error("HDMI outputs not zero in the cycle after reset release");

endmodule

bind scan_out scan_out_assert #(.COLOR_W(COLOR_W)) scan_out_assert_i (
    .CLK27_i          (CLK27_i),
    .po_reset_n       (po_reset_n),
    .extra_out_en_i   (extra_out_en_i),
    .extra_out_mode_i (extra_out_mode_i),
    .vga_vs_i         (vga_vs_o),
    .vga_sync_n_i     (vga_sync_n_o),
    .hdmitx_r_i       (hdmitx_r_o),
    .hdmitx_g_i       (hdmitx_g_o),
    .hdmitx_b_i       (hdmitx_b_o),
    .hdmitx_hsync_i   (hdmitx_hsync_o),
    .hdmitx_vsync_i   (hdmitx_vsync_o),
    .hdmitx_de_i      (hdmitx_de_o)
);

// File: sim/scan_out_tb.sv
// Reads sim/scan_out_stim.txt relative to the project root, one test per line.
// Outputs are compared on the falling edge, just before the next inputs are driven.

`timescale 1ns/1ns

module scan_out_tb import scan_out_pkg::*; ();

    typedef struct packed {
        logic [COLOR_W-1:0] r;
        logic [COLOR_W-1:0] g;
        logic [COLOR_W-1:0] b;
        logic               hs;
        logic               vs;
        logic               de;
    } pix_t;

    typedef struct packed {
        logic [COLOR_W-1:0] r;
        logic [COLOR_W-1:0] g;
        logic [COLOR_W-1:0] b;
        logic               hs;
        logic               vs;
        logic               blank_n;
        logic               sync_n;
    } vga_t;

    logic                   clk27;
    logic                   po_reset_n;
    capture_src_e           src_sel;
    logic                   osd_enable;
    logic [OSD_COLOR_W-1:0] osd_color;
    logic                   extra_out_en;
    extra_out_mode_e        extra_out_mode;
    pix_t                   isl_pix, hdmirx_pix, sdp_pix;
    logic [COLOR_W-1:0]     hdmitx_r, hdmitx_g, hdmitx_b, vga_r, vga_g, vga_b;
    logic                   hdmitx_hs, hdmitx_vs, hdmitx_de;
    logic                   vga_hs, vga_vs, vga_blank_n, vga_sync_n;

    // One entry per stim line
    int                     t_num[$], t_cycles[$];
    logic [1:0]             t_src[$], t_mode[$];
    logic                   t_osd[$], t_en[$];
    logic [OSD_COLOR_W-1:0] t_color[$];
    logic [3*COLOR_W-1:0]   t_word[$];

    // Reference pipeline state
    pix_t                   m_cap, m_out, m_hdmi;
    vga_t                   m_pre, m_vga;
    logic [3*COLOR_W-1:0]   cur_word;

    logic [31:0]            lcg_state = 32'h61d73b85;
    bit                     stim_ok;
    int                     test_errs, total_errs, tests_failed;
    int                     stim_total;
    int                     cycle_cnt;
    int                     cycle_limit = 0;

    scan_out #(.COLOR_W(COLOR_W)) scan_out_i (
        .CLK27_i          (clk27),
        .po_reset_n       (po_reset_n),
        .src_sel_i        (src_sel),
        .isl_r_i          (isl_pix.r),
        .isl_g_i          (isl_pix.g),
        .isl_b_i          (isl_pix.b),
        .isl_hs_i         (isl_pix.hs),
        .isl_vs_i         (isl_pix.vs),
        .isl_de_i         (isl_pix.de),
        .hdmirx_r_i       (hdmirx_pix.r),
        .hdmirx_g_i       (hdmirx_pix.g),
        .hdmirx_b_i       (hdmirx_pix.b),
        .hdmirx_hs_i      (hdmirx_pix.hs),
        .hdmirx_vs_i      (hdmirx_pix.vs),
        .hdmirx_de_i      (hdmirx_pix.de),
        .sdp_r_i          (sdp_pix.r),
        .sdp_g_i          (sdp_pix.g),
        .sdp_b_i          (sdp_pix.b),
        .sdp_hs_i         (sdp_pix.hs),
        .sdp_vs_i         (sdp_pix.vs),
        .sdp_de_i         (sdp_pix.de),
        .osd_enable_i     (osd_enable),
        .osd_color_i      (osd_color),
        .extra_out_en_i   (extra_out_en),
        .extra_out_mode_i (extra_out_mode),
        .hdmitx_r_o       (hdmitx_r),
        .hdmitx_g_o       (hdmitx_g),
        .hdmitx_b_o       (hdmitx_b),
        .hdmitx_hsync_o   (hdmitx_hs),
        .hdmitx_vsync_o   (hdmitx_vs),
        .hdmitx_de_o      (hdmitx_de),
        .vga_r_o          (vga_r),
        .vga_g_o          (vga_g),
        .vga_b_o          (vga_b),
        .vga_hs_o         (vga_hs),
        .vga_vs_o         (vga_vs),
        .vga_blank_n_o    (vga_blank_n),
        .vga_sync_n_o     (vga_sync_n)
    );

    initial begin
        clk27 = 1'b0;
        forever #20 clk27 = ~clk27;
    end

    initial begin
        cycle_cnt = 0;
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk27);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
        $display("TEST FAILED");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // High select bit picks the decoder, else the low bit picks HDMI RX
    function automatic pix_t pick_source(logic [1:0] sel, pix_t isl, pix_t rx, pix_t sdp);
        if (sel[1]) begin
            return sdp;
        end else if (sel[0]) begin
            return rx;
        end
        return isl;
    endfunction

    function automatic pix_t apply_osd(pix_t p, logic en, logic [3*COLOR_W-1:0] word);
        pix_t q;
        q = p;
        if (en) begin
            {q.r, q.g, q.b} = word;
        end
        return q;
    endfunction

    function automatic vga_t format_analog(pix_t p, extra_out_mode_e mode);
        vga_t v;
        logic cs;
        cs = ~(p.hs ^ p.vs);
        v.r       = p.r;
        v.g       = p.g;
        v.b       = p.b;
        v.blank_n = p.de;
        case (mode)
            MODE_RGBHV: begin
                v.hs     = p.hs;
                v.vs     = p.vs;
                v.sync_n = 1'b0;
            end
            MODE_RGBCS: begin
                v.hs     = cs;
                v.vs     = 1'b1;
                v.sync_n = 1'b0;
            end
            default: begin
                v.hs     = cs;
                v.vs     = 1'b1;
                v.sync_n = cs;
            end
        endcase
        return v;
    endfunction

    task automatic read_stim();
        int    fd;
        int    n;
        int    num, src, osd, col, en, mode, cyc, word;
        string line;
        stim_ok    = 1'b0;
        stim_total = 0;
        fd = $fopen("sim/scan_out_stim.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%d %d %d %h %d %d %d %h",
                                num, src, osd, col, en, mode, cyc, word);
                    if (n == 8) begin
                        t_num.push_back(num);
                        t_src.push_back(src[1:0]);
                        t_osd.push_back(osd[0]);
                        t_color.push_back(col[OSD_COLOR_W-1:0]);
                        t_en.push_back(en[0]);
                        t_mode.push_back(mode[1:0]);
                        t_cycles.push_back(cyc);
                        t_word.push_back(word[3*COLOR_W-1:0]);
                        stim_total += cyc;
                    end
                end
            end
            $fclose(fd);
            stim_ok = (t_num.size() > 0);
        end
    endtask

    task automatic randomize_sources();
        logic [31:0] rnd;
        rnd        = lcg_next();
        isl_pix    = rnd[31:32-$bits(pix_t)];
        rnd        = lcg_next();
        hdmirx_pix = rnd[31:32-$bits(pix_t)];
        rnd        = lcg_next();
        sdp_pix    = rnd[31:32-$bits(pix_t)];
    endtask

    // One clock of the reference pipeline, later stages first
    task automatic advance_model();
        if (extra_out_en) begin
            m_vga = m_pre;
            m_pre = format_analog(m_out, extra_out_mode);
        end
        m_hdmi = m_out;
        m_out  = apply_osd(m_cap, osd_enable, cur_word);
        m_cap  = pick_source(src_sel, isl_pix, hdmirx_pix, sdp_pix);
    endtask

    task automatic check_outputs();
        pix_t got_hdmi;
        vga_t got_vga;
        got_hdmi = {hdmitx_r, hdmitx_g, hdmitx_b, hdmitx_hs, hdmitx_vs, hdmitx_de};
        got_vga  = {vga_r, vga_g, vga_b, vga_hs, vga_vs, vga_blank_n, vga_sync_n};
        assert (got_hdmi === m_hdmi) else begin
            $display("ERR %0t: HDMI out %h, expected %h", $time, got_hdmi, m_hdmi);
            test_errs++;
        end
        assert (got_vga === m_vga) else begin
            $display("ERR %0t: VGA out %h, expected %h", $time, got_vga, m_vga);
            test_errs++;
        end
    endtask

    task automatic report_result(string name);
        $display("%s: %s, %0d errors", name, (test_errs == 0) ? "pass" : "fail", test_errs);
        total_errs += test_errs;
        if (test_errs != 0) begin
            tests_failed++;
        end
        test_errs = 0;
    endtask

    task automatic run_test(int idx);
        for (int c = 0; c < t_cycles[idx]; c++) begin
            @(negedge clk27);
            check_outputs();
            src_sel        = capture_src_e'(t_src[idx]);
            osd_enable     = t_osd[idx];
            osd_color      = t_color[idx];
            cur_word       = t_word[idx];
            extra_out_en   = t_en[idx];
            extra_out_mode = extra_out_mode_e'(t_mode[idx]);
            randomize_sources();
            advance_model();
        end
        report_result($sformatf("test %0d", t_num[idx]));
    endtask

    initial begin
        po_reset_n     = 1'b0;
        src_sel        = SRC_ISL;
        osd_enable     = 1'b0;
        osd_color      = '0;
        extra_out_en   = 1'b0;
        extra_out_mode = MODE_RGBHV;
        isl_pix        = '0;
        hdmirx_pix     = '0;
        sdp_pix        = '0;
        m_cap          = '0;
        m_out          = '0;
        m_hdmi         = '0;
        m_pre          = '0;
        m_vga          = '0;
        cur_word       = '0;
        test_errs      = 0;
        total_errs     = 0;
        tests_failed   = 0;
        read_stim();
        if (!stim_ok) begin
            $display("Stim file could not be read or holds no tests");
            $display("TEST FAILED");
        end else begin
            cycle_limit = stim_total + 50;
            repeat (3) @(negedge clk27);
            // Everything must still read zero while reset is held
            check_outputs();
            report_result("reset");
            po_reset_n = 1'b1;
            advance_model();
            for (int i = 0; i < t_num.size(); i++) begin
                run_test(i);
            end
            $display("Summary: %0d tests, %0d failed, %0d errors",
                     t_num.size(), tests_failed, total_errs);
            if (total_errs == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
        end
        $finish;
    end

endmodule

// File: sim/scan_out_stim.txt
# test src_sel osd_en osd_color(hex) extra_en mode cycles osd_word(hex)
# osd_word is the expected HDMI R G B while the OSD is on, 000000 otherwise
1  0 0 0 1 0 40 000000
2  1 0 0 1 0 40 000000
3  2 0 0 1 1 40 000000
4  3 0 0 1 2 40 000000
5  0 1 5 1 3 30 ff00ff
6  1 1 2 1 0 30 00ff00
7  2 1 7 1 1 30 ffffff
8  3 1 3 1 2 30 00ffff
9  1 0 0 0 2 30 000000
10 2 1 6 0 0 20 ffff00
11 0 1 1 1 1 30 0000ff
12 3 0 0 1 3 30 000000
13 1 1 4 1 0 20 ff0000

// File: scan_out.f
design/scan_out_pkg.sv
design/pixel_if.sv
design/capture_select.sv
design/osd_overlay.sv
design/analog_sync_format.sv
design/scan_out.sv
sim/scan_out_assert.sv
sim/scan_out_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the scan_out testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f scan_out.f --top-module scan_out_tb -Mdir obj_dir \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vscan_out_tb > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TEST OK" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed" && exit 0
